// ==== hdl/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define INST_W          32
`define REG_ADDR_W      5

`define OPC_SPECIAL     6'b000000
`define OPC_COP0        6'b010000
`define OPC_ADDI        6'b001000
`define OPC_ADDIU       6'b001001
`define OPC_SLTI        6'b001010
`define OPC_SLTIU       6'b001011
`define OPC_ANDI        6'b001100
`define OPC_ORI         6'b001101
`define OPC_XORI        6'b001110
`define OPC_LUI         6'b001111
`define OPC_LB          6'b100000
`define OPC_LH          6'b100001
`define OPC_LW          6'b100011
`define OPC_LBU         6'b100100
`define OPC_LHU         6'b100101
`define OPC_SB          6'b101000
`define OPC_SH          6'b101001
`define OPC_SW          6'b101011

`define FN_SLL          6'b000000
`define FN_SRL          6'b000010
`define FN_SRA          6'b000011
`define FN_SLLV         6'b000100
`define FN_SRLV         6'b000110
`define FN_SRAV         6'b000111
`define FN_SYSCALL      6'b001100
`define FN_BREAK        6'b001101
`define FN_MFHI         6'b010000
`define FN_MTHI         6'b010001
`define FN_MFLO         6'b010010
`define FN_MTLO         6'b010011
`define FN_MULT         6'b011000
`define FN_MULTU        6'b011001
`define FN_DIV          6'b011010
`define FN_DIVU         6'b011011
`define FN_ADD          6'b100000
`define FN_ADDU         6'b100001
`define FN_SUB          6'b100010
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_NOR          6'b100111
`define FN_SLT          6'b101010
`define FN_SLTU         6'b101011

`define COP0_RS_MF      5'b00000
`define COP0_RS_MT      5'b00100
`define ERET_WORD       32'h4200_0018
`define REG_LINK        5'd31

`endif

// ==== hdl/decode_pkg.sv ====
`include "decode_settings.svh"

package decode_pkg;

        typedef enum logic [5:0] {
                ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
                ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI,
                ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
                ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
                ALU_BREK, ALU_SYSC, ALU_ERET, ALU_MFC0, ALU_MTC0,
                ALU_OUTA // Passes operand A through
        } alu_op_e;

        typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_SFT, SRC_PCA} alu_src_e;

        typedef enum logic {SIGN_EXT, ZERO_EXT} ext_e;

        typedef enum logic [1:0] {MEM_NOOP, MEM_LOAD, MEM_STOR} mem_type_e;

        typedef enum logic [2:0] {SZ_FULL, SZ_BYTE, SZ_HALF} mem_size_e;

        // Same word seen as R format or I format
        typedef union packed {
                struct packed {
                        logic [5:0]             opcode;
                        logic [`REG_ADDR_W-1:0] rs;
                        logic [`REG_ADDR_W-1:0] rt;
                        logic [`REG_ADDR_W-1:0] rd;
                        logic [`REG_ADDR_W-1:0] shamt;
                        logic [5:0]             funct;
                } r_fmt;
                struct packed {
                        logic [5:0]             opcode;
                        logic [`REG_ADDR_W-1:0] rs;
                        logic [`REG_ADDR_W-1:0] rt;
                        logic [`INST_W/2-1:0]   imm;
                } i_fmt;
        } inst_word_u;

endpackage

// ==== hdl/special_decoder.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module special_decoder (
        input  decode_pkg::inst_word_u  inst,
        output logic                    hit,
        output decode_pkg::alu_op_e     alu_op,
        output decode_pkg::alu_src_e    alu_src,
        output decode_pkg::ext_e        alu_imm_src,
        output decode_pkg::mem_type_e   mem_type,
        output decode_pkg::mem_size_e   mem_size,
        output logic [`REG_ADDR_W-1:0]  wb_reg_dest,
        output logic                    wb_reg_en,
        output decode_pkg::ext_e        load_ext,
        output logic                    priv_inst
);
        import decode_pkg::*;

        always_comb begin
                hit = (inst.r_fmt.opcode == `OPC_SPECIAL);
                alu_op = ALU_ADDU;
                alu_src = SRC_REG;
                alu_imm_src = SIGN_EXT;
                mem_type = MEM_NOOP;
                mem_size = SZ_FULL;
                wb_reg_dest = inst.r_fmt.rd;
                wb_reg_en = 1'b1;
                load_ext = ZERO_EXT;
                priv_inst = 1'b0;
                case (inst.r_fmt.funct)
                `FN_ADD:  alu_op = ALU_ADD;
                `FN_ADDU: alu_op = ALU_ADDU;
                `FN_SUB:  alu_op = ALU_SUB;
                `FN_SUBU: alu_op = ALU_SUBU;
                `FN_SLT:  alu_op = ALU_SLT;
                `FN_SLTU: alu_op = ALU_SLTU;
                `FN_AND:  alu_op = ALU_AND;
                `FN_OR:   alu_op = ALU_OR;
                `FN_XOR:  alu_op = ALU_XOR;
                `FN_NOR:  alu_op = ALU_NOR;
                `FN_SLL, `FN_SLLV: alu_op = ALU_SLL;
                `FN_SRL, `FN_SRLV: alu_op = ALU_SRL;
                `FN_SRA, `FN_SRAV: alu_op = ALU_SRA;
                `FN_MULT:  alu_op = ALU_MULT;
                `FN_MULTU: alu_op = ALU_MULTU;
                `FN_DIV:   alu_op = ALU_DIV;
                `FN_DIVU:  alu_op = ALU_DIVU;
                `FN_MFHI:  alu_op = ALU_MFHI;
                `FN_MFLO:  alu_op = ALU_MFLO;
                `FN_MTHI:  alu_op = ALU_MTHI;
                `FN_MTLO:  alu_op = ALU_MTLO;
                `FN_BREAK: alu_op = ALU_BREK;
                `FN_SYSCALL: alu_op = ALU_SYSC;
                default: hit = 1'b0; // r1 additions land here too
                endcase

                case (inst.r_fmt.funct)
                `FN_SLL, `FN_SRL, `FN_SRA: alu_src = SRC_SFT; // Shift by shamt
                `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_MTHI, `FN_MTLO:
                        wb_reg_en = 1'b0; // Result goes to HI/LO
                `FN_BREAK, `FN_SYSCALL: begin
                        wb_reg_dest = inst.r_fmt.rt;
                        wb_reg_en = 1'b0;
                        priv_inst = 1'b1;
                end
                default: ;
                endcase
        end

        // Checked when the next word arrives, on settled values
        assert property (@(inst) hit && wb_reg_en |-> wb_reg_dest == inst.r_fmt.rd);

endmodule

// ==== hdl/imm_decoder.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module imm_decoder (
        input  decode_pkg::inst_word_u  inst,
        output logic                    hit,
        output decode_pkg::alu_op_e     alu_op,
        output decode_pkg::alu_src_e    alu_src,
        output decode_pkg::ext_e        alu_imm_src,
        output decode_pkg::mem_type_e   mem_type,
        output decode_pkg::mem_size_e   mem_size,
        output logic [`REG_ADDR_W-1:0]  wb_reg_dest,
        output logic                    wb_reg_en,
        output decode_pkg::ext_e        load_ext,
        output logic                    priv_inst
);
        import decode_pkg::*;

        always_comb begin
                hit = 1'b1;
                alu_op = ALU_ADDU;
                alu_src = SRC_IMM;
                alu_imm_src = SIGN_EXT;
                mem_type = MEM_NOOP;
                mem_size = SZ_FULL;
                wb_reg_dest = inst.i_fmt.rt;
                wb_reg_en = 1'b1;
                load_ext = ZERO_EXT;
                priv_inst = 1'b0;
                case (inst.i_fmt.opcode)
                `OPC_ADDI:  alu_op = ALU_ADD;
                `OPC_ADDIU: alu_op = ALU_ADDU;
                `OPC_SLTI:  alu_op = ALU_SLT;
                `OPC_SLTIU: alu_op = ALU_SLTU;
                `OPC_ANDI:  alu_op = ALU_AND;
                `OPC_ORI:   alu_op = ALU_OR;
                `OPC_XORI:  alu_op = ALU_XOR;
                `OPC_LUI:   alu_op = ALU_LUI;
                `OPC_LB, `OPC_LBU, `OPC_LH, `OPC_LHU, `OPC_LW: mem_type = MEM_LOAD;
                `OPC_SB, `OPC_SH, `OPC_SW: begin
                        mem_type = MEM_STOR;
                        wb_reg_en = 1'b0;
                end
                default: begin
                        hit = 1'b0;
                        alu_src = SRC_REG;
                        wb_reg_en = 1'b0;
                end
                endcase

                // Logic ops and LUI take the immediate unsigned
                if (inst.i_fmt.opcode[5:2] == 4'b0011)
                        alu_imm_src = ZERO_EXT;

                if (mem_type != MEM_NOOP) begin
                        case (inst.i_fmt.opcode[1:0])
                        2'b00:   mem_size = SZ_BYTE;
                        2'b01:   mem_size = SZ_HALF;
                        default: mem_size = SZ_FULL;
                        endcase
                        if (!inst.i_fmt.opcode[2] && mem_size != SZ_FULL)
                                load_ext = SIGN_EXT; // LB, LH, SB, SH
                end
        end

        assert property (@(inst) hit && mem_type == MEM_STOR |-> !wb_reg_en);

endmodule

// ==== hdl/cop0_decoder.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module cop0_decoder (
        input  decode_pkg::inst_word_u  inst,
        output logic                    hit,
        output decode_pkg::alu_op_e     alu_op,
        output decode_pkg::alu_src_e    alu_src,
        output decode_pkg::ext_e        alu_imm_src,
        output decode_pkg::mem_type_e   mem_type,
        output decode_pkg::mem_size_e   mem_size,
        output logic [`REG_ADDR_W-1:0]  wb_reg_dest,
        output logic                    wb_reg_en,
        output decode_pkg::ext_e        load_ext,
        output logic                    priv_inst
);
        import decode_pkg::*;

        always_comb begin
                hit = (inst.r_fmt.opcode == `OPC_COP0);
                alu_op = ALU_ADDU;
                alu_src = SRC_REG;
                alu_imm_src = SIGN_EXT;
                mem_type = MEM_NOOP;
                mem_size = SZ_FULL;
                wb_reg_dest = inst.r_fmt.rt;
                wb_reg_en = 1'b0;
                load_ext = ZERO_EXT;
                priv_inst = hit; // Whole group is privileged
                if (inst == `ERET_WORD) begin
                        alu_op = ALU_ERET;
                end else if (inst.r_fmt.rs == `COP0_RS_MF) begin
                        alu_op = ALU_MFC0;
                        wb_reg_en = hit;
                end else if (inst.r_fmt.rs == `COP0_RS_MT) begin
                        alu_op = ALU_MTC0;
                end
        end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage (
        input  logic                    clk,
        input  logic                    arst_n,
        input  logic                    in_valid,
        input  decode_pkg::inst_word_u  inst,
        input  logic                    is_branch,
        input  logic                    is_branch_al,
        input  logic                    sp_hit, im_hit, c0_hit,
        input  decode_pkg::alu_op_e     sp_alu_op, im_alu_op, c0_alu_op,
        input  decode_pkg::alu_src_e    sp_alu_src, im_alu_src, c0_alu_src,
        input  decode_pkg::ext_e        sp_alu_imm_src, im_alu_imm_src, c0_alu_imm_src,
        input  decode_pkg::mem_type_e   sp_mem_type, im_mem_type, c0_mem_type,
        input  decode_pkg::mem_size_e   sp_mem_size, im_mem_size, c0_mem_size,
        input  logic [`REG_ADDR_W-1:0]  sp_wb_reg_dest, im_wb_reg_dest, c0_wb_reg_dest,
        input  logic                    sp_wb_reg_en, im_wb_reg_en, c0_wb_reg_en,
        input  decode_pkg::ext_e        sp_load_ext, im_load_ext, c0_load_ext,
        input  logic                    sp_priv_inst, im_priv_inst, c0_priv_inst,
        output logic                    out_valid,
        output decode_pkg::alu_op_e     alu_op,
        output decode_pkg::alu_src_e    alu_src,
        output decode_pkg::ext_e        alu_imm_src,
        output decode_pkg::mem_type_e   mem_type,
        output decode_pkg::mem_size_e   mem_size,
        output logic [`REG_ADDR_W-1:0]  wb_reg_dest,
        output logic                    wb_reg_en,
        output decode_pkg::ext_e        load_ext,
        output logic                    priv_inst,
        output logic                    undefined_inst
);
        import decode_pkg::*;

        logic                   any_hit;
        logic                   link;
        alu_op_e                sel_alu_op;
        alu_src_e               sel_alu_src;
        ext_e                   sel_alu_imm_src;
        mem_type_e              sel_mem_type;
        mem_size_e              sel_mem_size;
        logic [`REG_ADDR_W-1:0] sel_wb_reg_dest;
        logic                   sel_wb_reg_en;
        ext_e                   sel_load_ext;
        logic                   sel_priv_inst;

        assign any_hit = sp_hit | im_hit | c0_hit;
        assign link = is_branch & is_branch_al; // Branch-and-link fallback

        assign sel_alu_op = sp_hit ? sp_alu_op : im_hit ? im_alu_op : c0_hit ? c0_alu_op :
                        link ? ALU_OUTA : ALU_ADDU;
        assign sel_alu_src = sp_hit ? sp_alu_src : im_hit ? im_alu_src : c0_hit ? c0_alu_src :
                        link ? SRC_PCA : SRC_REG;
        assign sel_alu_imm_src = sp_hit ? sp_alu_imm_src : im_hit ? im_alu_imm_src :
                        c0_hit ? c0_alu_imm_src : SIGN_EXT;
        assign sel_mem_type = sp_hit ? sp_mem_type : im_hit ? im_mem_type :
                        c0_hit ? c0_mem_type : MEM_NOOP;
        assign sel_mem_size = sp_hit ? sp_mem_size : im_hit ? im_mem_size :
                        c0_hit ? c0_mem_size : SZ_FULL;
        assign sel_wb_reg_dest = sp_hit ? sp_wb_reg_dest : im_hit ? im_wb_reg_dest :
                        c0_hit ? c0_wb_reg_dest : link ? `REG_LINK : inst.r_fmt.rt;
        assign sel_load_ext = sp_hit ? sp_load_ext : im_hit ? im_load_ext :
                        c0_hit ? c0_load_ext : ZERO_EXT;
        assign sel_wb_reg_en = (sp_hit & sp_wb_reg_en) | (im_hit & im_wb_reg_en) |
                        (c0_hit & c0_wb_reg_en) | (!any_hit & link);
        assign sel_priv_inst = (sp_hit & sp_priv_inst) | (im_hit & im_priv_inst) |
                        (c0_hit & c0_priv_inst);

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        out_valid <= 1'b0;
                        wb_reg_en <= 1'b0;
                        undefined_inst <= 1'b0;
                        priv_inst <= 1'b0;
                        mem_type <= MEM_NOOP;
                end else begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                wb_reg_en <= sel_wb_reg_en;
                                undefined_inst <= !any_hit && !is_branch;
                                priv_inst <= sel_priv_inst;
                                mem_type <= sel_mem_type;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid) begin
                        alu_op <= sel_alu_op;
                        alu_src <= sel_alu_src;
                        alu_imm_src <= sel_alu_imm_src;
                        mem_size <= sel_mem_size;
                        wb_reg_dest <= sel_wb_reg_dest;
                        load_ext <= sel_load_ext;
                end
        end

        // Decoders own disjoint opcode ranges
        assert property (@(posedge clk) disable iff (!arst_n)
                in_valid |-> $onehot0({sp_hit, im_hit, c0_hit}));

endmodule

// ==== hdl/decode_top.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_top (
        input  logic                    clk,
        input  logic                    arst_n,
        input  logic                    in_valid,
        input  decode_pkg::inst_word_u  inst,
        input  logic                    is_branch,
        input  logic                    is_branch_al,
        output logic                    out_valid,
        output decode_pkg::alu_op_e     alu_op,
        output decode_pkg::alu_src_e    alu_src,
        output decode_pkg::ext_e        alu_imm_src,
        output decode_pkg::mem_type_e   mem_type,
        output decode_pkg::mem_size_e   mem_size,
        output logic [`REG_ADDR_W-1:0]  wb_reg_dest,
        output logic                    wb_reg_en,
        output decode_pkg::ext_e        load_ext,
        output logic                    priv_inst,
        output logic                    undefined_inst
);
        import decode_pkg::*;

        logic                   sp_hit, im_hit, c0_hit;
        alu_op_e                sp_alu_op, im_alu_op, c0_alu_op;
        alu_src_e               sp_alu_src, im_alu_src, c0_alu_src;
        ext_e                   sp_alu_imm_src, im_alu_imm_src, c0_alu_imm_src;
        mem_type_e              sp_mem_type, im_mem_type, c0_mem_type;
        mem_size_e              sp_mem_size, im_mem_size, c0_mem_size;
        logic [`REG_ADDR_W-1:0] sp_wb_reg_dest, im_wb_reg_dest, c0_wb_reg_dest;
        logic                   sp_wb_reg_en, im_wb_reg_en, c0_wb_reg_en;
        ext_e                   sp_load_ext, im_load_ext, c0_load_ext;
        logic                   sp_priv_inst, im_priv_inst, c0_priv_inst;

        special_decoder sp_dec_inst (
                .inst(inst), .hit(sp_hit), .alu_op(sp_alu_op), .alu_src(sp_alu_src),
                .alu_imm_src(sp_alu_imm_src), .mem_type(sp_mem_type), .mem_size(sp_mem_size),
                .wb_reg_dest(sp_wb_reg_dest), .wb_reg_en(sp_wb_reg_en),
                .load_ext(sp_load_ext), .priv_inst(sp_priv_inst)
        );

        imm_decoder im_dec_inst (
                .inst(inst), .hit(im_hit), .alu_op(im_alu_op), .alu_src(im_alu_src),
                .alu_imm_src(im_alu_imm_src), .mem_type(im_mem_type), .mem_size(im_mem_size),
                .wb_reg_dest(im_wb_reg_dest), .wb_reg_en(im_wb_reg_en),
                .load_ext(im_load_ext), .priv_inst(im_priv_inst)
        );

        cop0_decoder c0_dec_inst (
                .inst(inst), .hit(c0_hit), .alu_op(c0_alu_op), .alu_src(c0_alu_src),
                .alu_imm_src(c0_alu_imm_src), .mem_type(c0_mem_type), .mem_size(c0_mem_size),
                .wb_reg_dest(c0_wb_reg_dest), .wb_reg_en(c0_wb_reg_en),
                .load_ext(c0_load_ext), .priv_inst(c0_priv_inst)
        );

        decode_stage stage_inst (.*); // Port names match the wires above

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
        parameter real PERIOD_NS = 8.0
) (
        output logic clk
);
        initial clk = 1'b0;

        always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// ==== sim/decode_vectors.svh ====
        // Columns are name, word, random field mask, {is_branch, is_branch_al}, then expected
        // alu_op, alu_src, imm ext, mem type, mem size, load ext, dest, wb_en, priv, undef
        task automatic load_vectors();
                add_case("ADD", {`OPC_SPECIAL, 20'd0, `FN_ADD}, RND_R, 2'b00, ALU_ADD,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("SUBU", {`OPC_SPECIAL, 20'd0, `FN_SUBU}, RND_R, 2'b00, ALU_SUBU,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("SLT", {`OPC_SPECIAL, 20'd0, `FN_SLT}, RND_R, 2'b00, ALU_SLT,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("AND", {`OPC_SPECIAL, 20'd0, `FN_AND}, RND_R, 2'b00, ALU_AND,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("NOR", {`OPC_SPECIAL, 20'd0, `FN_NOR}, RND_R, 2'b00, ALU_NOR,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("SRA", {`OPC_SPECIAL, 15'd0, 5'd7, `FN_SRA}, RND_R, 2'b00, ALU_SRA,
                        SRC_SFT, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("SLLV", {`OPC_SPECIAL, 20'd0, `FN_SLLV}, RND_R, 2'b00, ALU_SLL,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("MULT", {`OPC_SPECIAL, 20'd0, `FN_MULT}, RND_R, 2'b00, ALU_MULT,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_ANY, 1'b0, 1'b0, 1'b0);
                add_case("MTHI", {`OPC_SPECIAL, 20'd0, `FN_MTHI}, RND_R, 2'b00, ALU_MTHI,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_ANY, 1'b0, 1'b0, 1'b0);
                add_case("MFLO", {`OPC_SPECIAL, 20'd0, `FN_MFLO}, RND_R, 2'b00, ALU_MFLO,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RD, 1'b1, 1'b0, 1'b0);
                add_case("BREAK", {`OPC_SPECIAL, 20'd0, `FN_BREAK}, RND_R, 2'b00, ALU_BREK,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b0, 1'b1, 1'b0);
                add_case("SYSCALL", {`OPC_SPECIAL, 20'd0, `FN_SYSCALL}, RND_R, 2'b00, ALU_SYSC,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b0, 1'b1, 1'b0);
                add_case("ADDI", {`OPC_ADDI, 26'd0}, RND_I, 2'b00, ALU_ADD,
                        SRC_IMM, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b1, 1'b0, 1'b0);
                add_case("ANDI", {`OPC_ANDI, 26'd0}, RND_I, 2'b00, ALU_AND,
                        SRC_IMM, ZERO_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b1, 1'b0, 1'b0);
                add_case("LB", {`OPC_LB, 26'd0}, RND_I, 2'b00, ALU_ADDU,
                        SRC_IMM, SIGN_EXT, MEM_LOAD, SZ_BYTE, SIGN_EXT, D_RT, 1'b1, 1'b0, 1'b0);
                add_case("LHU", {`OPC_LHU, 26'd0}, RND_I, 2'b00, ALU_ADDU,
                        SRC_IMM, SIGN_EXT, MEM_LOAD, SZ_HALF, ZERO_EXT, D_RT, 1'b1, 1'b0, 1'b0);
                add_case("SW", {`OPC_SW, 26'd0}, RND_I, 2'b00, ALU_ADDU,
                        SRC_IMM, SIGN_EXT, MEM_STOR, SZ_FULL, ZERO_EXT, D_ANY, 1'b0, 1'b0, 1'b0);
                add_case("ERET", `ERET_WORD, 32'd0, 2'b00, ALU_ERET,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_ANY, 1'b0, 1'b1, 1'b0);
                add_case("MFC0", {`OPC_COP0, `COP0_RS_MF, 21'd0}, RND_C0, 2'b00, ALU_MFC0,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b1, 1'b1, 1'b0);
                add_case("MTC0", {`OPC_COP0, `COP0_RS_MT, 21'd0}, RND_C0, 2'b00, ALU_MTC0,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_ANY, 1'b0, 1'b1, 1'b0);
                add_case("BGEZAL", 32'h0411_0000, RND_I, 2'b11, ALU_OUTA, // Link fallback
                        SRC_PCA, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_LINK, 1'b1, 1'b0, 1'b0);
                add_case("BEQ", 32'h1000_0000, RND_I, 2'b10, ALU_ADDU,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b0, 1'b0, 1'b0);
                add_case("CLZ", 32'h7000_0020, RND_R, 2'b00, ALU_ADDU, // Dropped r1 encoding
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b0, 1'b0, 1'b1);
                add_case("MOVZ", {`OPC_SPECIAL, 20'd0, 6'b001010}, RND_R, 2'b00, ALU_ADDU,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b0, 1'b0, 1'b1);
                add_case("OPC_3F", 32'hFC00_0000, RND_I, 2'b00, ALU_ADDU,
                        SRC_REG, SIGN_EXT, MEM_NOOP, SZ_FULL, ZERO_EXT, D_RT, 1'b0, 1'b0, 1'b1);
        endtask

// ==== sim/decode_tb.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_tb;
        import decode_pkg::*;

        localparam int MAX_ROWS = 40;
        localparam logic [31:0] RND_R = 32'h03FF_F800;  // rs, rt, rd
        localparam logic [31:0] RND_I = 32'h03FF_FFFF;  // rs, rt, imm
        localparam logic [31:0] RND_C0 = 32'h001F_F800; // rt and cp0 register
        localparam logic [1:0] D_RD = 2'd0, D_RT = 2'd1, D_LINK = 2'd2, D_ANY = 2'd3;

        logic                   clk, arst_n, in_valid, is_branch, is_branch_al;
        inst_word_u             inst;
        logic                   out_valid, wb_reg_en, priv_inst, undefined_inst;
        alu_op_e                alu_op;
        alu_src_e               alu_src;
        ext_e                   alu_imm_src, load_ext;
        mem_type_e              mem_type;
        mem_size_e              mem_size;
        logic [`REG_ADDR_W-1:0] wb_reg_dest;
        logic [22:0]            ctrl; // Destination sits in bits 7:3

        string                  row_name [MAX_ROWS];
        logic [31:0]            row_word [MAX_ROWS];
        logic [1:0]             row_br [MAX_ROWS]; // {is_branch, is_branch_al}
        logic [22:0]            row_exp [MAX_ROWS];
        logic [22:0]            row_care [MAX_ROWS];
        int                     num_rows = 0;
        int                     cycle_count = 0;
        int                     cycle_limit = 1000;
        integer                 seed = 32'h2b80c64c;

        assign ctrl = {alu_op, alu_src, alu_imm_src, mem_type, mem_size, load_ext,
                        wb_reg_dest, wb_reg_en, priv_inst, undefined_inst};

        tb_clock clk_gen_inst (.clk(clk));
        decode_top decode_top_inst (.*);

        task automatic add_case(input string name, input logic [31:0] word,
                        input logic [31:0] rnd_mask, input logic [1:0] br,
                        input alu_op_e op, input alu_src_e src, input ext_e imm_ext,
                        input mem_type_e mtype, input mem_size_e msize, input ext_e lext,
                        input logic [1:0] dest, input logic wb, input logic priv,
                        input logic undef);
                logic [31:0] w;
                logic [4:0]  dest_exp;
                w = (word & ~rnd_mask) | ($random(seed) & rnd_mask);
                dest_exp = (dest == D_RD) ? w[15:11] : (dest == D_LINK) ? 5'd31 : w[20:16];
                row_name[num_rows] = name;
                row_word[num_rows] = w;
                row_br[num_rows] = br;
                row_care[num_rows] = (dest == D_ANY) ? ~(23'd31 << 3) : '1;
                row_exp[num_rows] = {op, src, imm_ext, mtype, msize, lext, dest_exp,
                        wb, priv, undef} & row_care[num_rows];
                num_rows++;
        endtask

        `include "decode_vectors.svh"

        task automatic check_value(input string test, input string field,
                        input logic [31:0] expected, input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("Error %s %s: expected %0h, actual %0h", test, field,
                                expected, actual);
                        $display("Checks failed");
                        $fatal(1, "Stopped at the first mismatch");
                end
        endtask

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= cycle_limit) begin
                        $display("Checks failed");
                        $fatal(1, "Timeout, the run did not end within %0d cycles", cycle_limit);
                end
        end

        initial begin
                arst_n = 1'b0;
                in_valid = 1'b0;
                inst = '0;
                is_branch = 1'b0;
                is_branch_al = 1'b0;
                load_vectors();
                cycle_limit = 16 + 3 * num_rows + 20;
                repeat (16) @(posedge clk);
                @(negedge clk);
                check_value("reset", "status", 32'({4'b0000, MEM_NOOP}),
                        32'({out_valid, wb_reg_en, undefined_inst, priv_inst, mem_type}));
                arst_n = 1'b1;
                @(negedge clk);
                check_value("idle", "out_valid", 32'd0, 32'(out_valid));
                for (int i = 0; i < num_rows; i++) begin
                        inst = row_word[i];
                        {is_branch, is_branch_al} = row_br[i];
                        in_valid = 1'b1;
                        if (i == 0) begin
                                #1;
                                check_value(row_name[i], "early out_valid", 32'd0,
                                        32'(out_valid));
                        end
                        @(negedge clk); // One cycle after the strobe
                        check_value(row_name[i], "out_valid", 32'd1, 32'(out_valid));
                        check_value(row_name[i], "control", 32'(row_exp[i]),
                                32'(ctrl & row_care[i]));
                end
                in_valid = 1'b0;
                inst = $random(seed);
                @(negedge clk);
                // Last decoded word must hold
                check_value("hold", "out_valid", 32'd0, 32'(out_valid));
                check_value("hold", "control", 32'(row_exp[num_rows-1]),
                        32'(ctrl & row_care[num_rows-1]));
                $display("All checks passed");
                $finish;
        end

endmodule

// ==== files.f ====
+incdir+hdl
+incdir+sim
hdl/decode_pkg.sv
hdl/special_decoder.sv
hdl/imm_decoder.sv
hdl/cop0_decoder.sv
hdl/decode_stage.sv
hdl/decode_top.sv
sim/tb_clock.sv
sim/decode_tb.sv
